// File: renamePkg.sv
package renamePkg;

    // Architectural and physical register file sizes
    localparam int numArchRegs = 32;
    localparam int numTags = 64;

    localparam int regIdWidth = 5;
    localparam int tagWidth = 6;
    localparam int sqNWidth = 7;

    // Wide enough to count every free tag of the FIFO
    localparam int countWidth = 7;

    typedef logic [regIdWidth-1:0] RegId;
    typedef logic [tagWidth-1:0] Tag;

    // Wraps around, compare with signed differences
    typedef logic [sqNWidth-1:0] SqN;

    // Target unit, only carried through rename
    typedef enum logic [2:0] {
        fuInt,
        fuMul,
        fuDiv,
        fuLsu,
        fuBranch
    } FuType;

    // Op as it leaves decode
    typedef struct packed {
        logic valid;
        RegId rs1;
        RegId rs2;
        RegId rd;
        FuType fu;
        logic [31:0] imm;
    } DecUop;

    // Op after rename, toward the issue queues
    typedef struct packed {
        logic valid;
        Tag tagA;
        logic availA;
        Tag tagB;
        logic availB;
        logic hasDst;
        Tag tagDst;
        RegId rd;
        SqN sqN;
        FuType fu;
        logic [31:0] imm;
    } RenUop;

    // In-order commit from the ROB
    typedef struct packed {
        logic valid;
        RegId rd;
        Tag tagDst;
    } CommitUop;

    // Result broadcast, marks a tag ready
    typedef struct packed {
        logic valid;
        Tag tag;
    } WbUop;

    // sqN is the youngest op that survives the flush
    typedef struct packed {
        logic taken;
        SqN sqN;
    } BranchInfo;

endpackage

// File: renameTable.sv
`timescale 1ns/1ps

module renameTable #(
    parameter int issueWidth = 2,
    parameter int commitWidth = 2,
    parameter int wbWidth = 2
) (
    input logic clk,
    input logic rst,

    input renamePkg::RegId lookupIds [2*issueWidth],
    output renamePkg::Tag lookupTags [2*issueWidth],
    output logic lookupAvail [2*issueWidth],

    input logic issueValid [issueWidth],
    input renamePkg::RegId issueIds [issueWidth],
    input renamePkg::Tag issueTags [issueWidth],

    input renamePkg::CommitUop commitUop [commitWidth],
    output renamePkg::Tag commitPrevTags [commitWidth],

    input renamePkg::WbUop wbUop [wbWidth],
    input renamePkg::BranchInfo branch
);

    localparam int numRegs = renamePkg::numArchRegs;

    renamePkg::Tag specMap [numRegs];
    renamePkg::Tag comMap [numRegs];
    renamePkg::Tag comMapNext [numRegs];
    logic [renamePkg::numTags-1:0] ready;

    // Source lookup against the speculative map
    always_comb begin
        for (int i = 0; i < 2*issueWidth; i++) begin
            lookupTags[i] = specMap[lookupIds[i]];
            lookupAvail[i] = ready[lookupTags[i]];
            // A result broadcast this cycle already counts as ready
            for (int w = 0; w < wbWidth; w++) begin
                if (wbUop[w].valid && wbUop[w].tag == lookupTags[i]) begin
                    lookupAvail[i] = 1'b1;
                end
            end
        end
    end

    // Tag that each commit slot replaces in the committed map
    always_comb begin
        for (int i = 0; i < commitWidth; i++) begin
            commitPrevTags[i] = comMap[commitUop[i].rd];
            // An older slot of the same group may have remapped this rd already
            for (int j = 0; j < i; j++) begin
                if (commitUop[j].valid && commitUop[j].rd == commitUop[i].rd) begin
                    commitPrevTags[i] = commitUop[j].tagDst;
                end
            end
        end
    end

    // Committed map after this cycle's commits, newest slot last
    always_comb begin
        comMapNext = comMap;
        for (int i = 0; i < commitWidth; i++) begin
            if (commitUop[i].valid && commitUop[i].rd != '0) begin
                comMapNext[commitUop[i].rd] = commitUop[i].tagDst;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping, every tag holds a value
            for (int r = 0; r < numRegs; r++) begin
                specMap[r] <= renamePkg::Tag'(r);
                comMap[r] <= renamePkg::Tag'(r);
            end
            ready <= '1;
        end else begin
            comMap <= comMapNext;

            if (branch.taken) begin
                // Drop everything speculative
                specMap <= comMapNext;
            end else begin
                // Later slots overwrite earlier ones with the same rd
                for (int i = 0; i < issueWidth; i++) begin
                    if (issueValid[i]) begin
                        specMap[issueIds[i]] <= issueTags[i];
                    end
                end
            end

            for (int i = 0; i < issueWidth; i++) begin
                if (issueValid[i] && !branch.taken) begin
                    ready[issueTags[i]] <= 1'b0;
                end
            end

            for (int w = 0; w < wbWidth; w++) begin
                if (wbUop[w].valid) begin
                    ready[wbUop[w].tag] <= 1'b1;
                end
            end
        end
    end

endmodule

// File: tagBuffer.sv
`timescale 1ns/1ps

module tagBuffer #(
    parameter int issueWidth = 2,
    parameter int commitWidth = 2
) (
    input logic clk,
    input logic rst,

    input logic allocValid [issueWidth],
    output renamePkg::Tag freeTags [issueWidth],
    output logic [renamePkg::countWidth-1:0] freeCount,

    input renamePkg::CommitUop commitUop [commitWidth],
    input renamePkg::Tag commitPrevTags [commitWidth],

    input renamePkg::BranchInfo branch
);

    // One slot per tag that is not part of the initial identity map
    localparam int depth = renamePkg::numTags - renamePkg::numArchRegs;
    // Extra wrap bit tells a full FIFO from an empty one
    localparam int ptrBits = $clog2(depth) + 1;
    localparam int countBits = renamePkg::countWidth;

    renamePkg::Tag fifo [depth];

    logic [ptrBits-1:0] specHead;
    logic [ptrBits-1:0] comHead;
    logic [ptrBits-1:0] tail;
    logic [ptrBits-1:0] fillLevel;

    logic [ptrBits-1:0] allocCount;
    logic [ptrBits-1:0] readPtr [issueWidth];

    logic pushValid [commitWidth];
    logic [ptrBits-1:0] pushPtr [commitWidth];
    logic [ptrBits-1:0] pushCount;

    // Next free tags in FIFO order, starting at the speculative head
    always_comb begin
        allocCount = '0;
        for (int k = 0; k < issueWidth; k++) begin
            readPtr[k] = specHead + ptrBits'(k);
            freeTags[k] = fifo[readPtr[k][ptrBits-2:0]];
            if (allocValid[k]) begin
                allocCount = allocCount + 1'b1;
            end
        end
    end

    // Every commit that writes a register frees exactly one tag
    always_comb begin
        pushCount = '0;
        for (int i = 0; i < commitWidth; i++) begin
            pushValid[i] = commitUop[i].valid && commitUop[i].rd != '0;
            pushPtr[i] = tail + pushCount;
            if (pushValid[i]) begin
                pushCount = pushCount + 1'b1;
            end
        end
    end

    assign fillLevel = tail - specHead;
    assign freeCount = countBits'(fillLevel);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                fifo[i] <= renamePkg::Tag'(renamePkg::numArchRegs + i);
            end
            specHead <= '0;
            comHead <= '0;
            // Full at reset
            tail <= ptrBits'(depth);
        end else begin
            for (int i = 0; i < commitWidth; i++) begin
                if (pushValid[i]) begin
                    fifo[pushPtr[i][ptrBits-2:0]] <= commitPrevTags[i];
                end
            end
            tail <= tail + pushCount;
            comHead <= comHead + pushCount;

            // Rewind to the committed head including this cycle's commits
            if (branch.taken) begin
                specHead <= comHead + pushCount;
            end else begin
                specHead <= specHead + allocCount;
            end
        end
    end

endmodule

// File: renameStage.sv
`timescale 1ns/1ps

module renameStage #(
    parameter int issueWidth = 2,
    parameter int wbWidth = 2
) (
    input logic clk,
    input logic rst,
    input logic frontEn,
    input logic outStall,

    input renamePkg::DecUop decUop [issueWidth],
    output renamePkg::RenUop renUop [issueWidth],
    output logic stall,
    output renamePkg::SqN nextSqN,

    output renamePkg::RegId lookupIds [2*issueWidth],
    input renamePkg::Tag lookupTags [2*issueWidth],
    input logic lookupAvail [2*issueWidth],

    output logic issueValid [issueWidth],
    output renamePkg::RegId issueIds [issueWidth],
    output renamePkg::Tag issueTags [issueWidth],

    output logic allocValid [issueWidth],
    input renamePkg::Tag freeTags [issueWidth],
    input logic [renamePkg::countWidth-1:0] freeCount,

    input renamePkg::WbUop wbUop [wbWidth],
    input renamePkg::BranchInfo branch
);

    localparam int slotBits = (issueWidth > 1) ? $clog2(issueWidth) : 1;

    renamePkg::SqN seqCounter;
    renamePkg::SqN groupCount;
    renamePkg::SqN opSqN [issueWidth];

    logic needTag [issueWidth];
    logic [slotBits-1:0] tagIdx [issueWidth];
    logic [renamePkg::countWidth-1:0] tagsNeeded;
    renamePkg::Tag newTag [issueWidth];

    renamePkg::RenUop renamed [issueWidth];
    logic accept;

    // Slot order decides which free tag and which sequence number each op gets
    always_comb begin
        tagsNeeded = '0;
        groupCount = '0;
        for (int i = 0; i < issueWidth; i++) begin
            // x0 is never renamed
            needTag[i] = decUop[i].valid && decUop[i].rd != '0;
            tagIdx[i] = tagsNeeded[slotBits-1:0];
            opSqN[i] = seqCounter + groupCount;
            if (needTag[i]) begin
                tagsNeeded = tagsNeeded + 1'b1;
            end
            if (decUop[i].valid) begin
                groupCount = groupCount + 1'b1;
            end
        end
    end

    assign stall = outStall || (tagsNeeded > freeCount);
    assign accept = frontEn && !stall && !branch.taken;
    assign nextSqN = seqCounter;

    always_comb begin
        for (int i = 0; i < issueWidth; i++) begin
            newTag[i] = needTag[i] ? freeTags[tagIdx[i]] : '0;

            lookupIds[2*i] = decUop[i].rs1;
            lookupIds[2*i+1] = decUop[i].rs2;

            issueValid[i] = accept && needTag[i];
            issueIds[i] = decUop[i].rd;
            issueTags[i] = newTag[i];
            allocValid[i] = accept && needTag[i];
        end
    end

    // Build the renamed group, with bypass from older slots of the same group
    always_comb begin
        for (int i = 0; i < issueWidth; i++) begin
            renamed[i].valid = decUop[i].valid;
            renamed[i].tagA = lookupTags[2*i];
            renamed[i].availA = lookupAvail[2*i];
            renamed[i].tagB = lookupTags[2*i+1];
            renamed[i].availB = lookupAvail[2*i+1];
            renamed[i].hasDst = needTag[i];
            renamed[i].tagDst = newTag[i];
            renamed[i].rd = decUop[i].rd;
            renamed[i].sqN = opSqN[i];
            renamed[i].fu = decUop[i].fu;
            renamed[i].imm = decUop[i].imm;

            // Youngest older writer wins, its result cannot be ready yet
            for (int j = 0; j < i; j++) begin
                if (needTag[j] && decUop[j].rd == decUop[i].rs1) begin
                    renamed[i].tagA = newTag[j];
                    renamed[i].availA = 1'b0;
                end
                if (needTag[j] && decUop[j].rd == decUop[i].rs2) begin
                    renamed[i].tagB = newTag[j];
                    renamed[i].availB = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            seqCounter <= '0;
            for (int i = 0; i < issueWidth; i++) begin
                renUop[i].valid <= 1'b0;
            end
        end else if (branch.taken) begin
            // A flush drops every op that is not committed
            seqCounter <= branch.sqN + 1'b1;
            for (int i = 0; i < issueWidth; i++) begin
                renUop[i].valid <= 1'b0;
            end
        end else if (accept) begin
            seqCounter <= seqCounter + groupCount;
            renUop <= renamed;
        end else if (outStall) begin
            // Held ops are read later, so keep their ready bits current
            for (int w = 0; w < wbWidth; w++) begin
                for (int i = 0; i < issueWidth; i++) begin
                    if (wbUop[w].valid && renUop[i].valid) begin
                        if (renUop[i].tagA == wbUop[w].tag) begin
                            renUop[i].availA <= 1'b1;
                        end
                        if (renUop[i].tagB == wbUop[w].tag) begin
                            renUop[i].availB <= 1'b1;
                        end
                    end
                end
            end
        end else begin
            for (int i = 0; i < issueWidth; i++) begin
                renUop[i].valid <= 1'b0;
            end
        end
    end

endmodule

// File: renameTop.sv
`timescale 1ns/1ps

module renameTop #(
    parameter int issueWidth = 2,
    parameter int commitWidth = 2,
    parameter int wbWidth = 2
) (
    input logic clk,
    input logic rst,

    input renamePkg::DecUop decUop [issueWidth],
    input logic frontEn,
    input logic outStall,
    input renamePkg::CommitUop commitUop [commitWidth],
    input renamePkg::WbUop wbUop [wbWidth],
    input renamePkg::BranchInfo branch,

    output renamePkg::RenUop renUop [issueWidth],
    output logic stall,
    output renamePkg::SqN nextSqN
);

    // Stage to table
    renamePkg::RegId lookupIds [2*issueWidth];
    renamePkg::Tag lookupTags [2*issueWidth];
    logic lookupAvail [2*issueWidth];
    logic issueValid [issueWidth];
    renamePkg::RegId issueIds [issueWidth];
    renamePkg::Tag issueTags [issueWidth];

    // Stage to free-tag FIFO
    logic allocValid [issueWidth];
    renamePkg::Tag freeTags [issueWidth];
    logic [renamePkg::countWidth-1:0] freeCount;

    // Table to free-tag FIFO
    renamePkg::Tag commitPrevTags [commitWidth];

    renameTable #(
        .issueWidth(issueWidth),
        .commitWidth(commitWidth),
        .wbWidth(wbWidth)
    ) renameTable_inst (
        .clk(clk),
        .rst(rst),
        .lookupIds(lookupIds),
        .lookupTags(lookupTags),
        .lookupAvail(lookupAvail),
        .issueValid(issueValid),
        .issueIds(issueIds),
        .issueTags(issueTags),
        .commitUop(commitUop),
        .commitPrevTags(commitPrevTags),
        .wbUop(wbUop),
        .branch(branch)
    );

    tagBuffer #(
        .issueWidth(issueWidth),
        .commitWidth(commitWidth)
    ) tagBuffer_inst (
        .clk(clk),
        .rst(rst),
        .allocValid(allocValid),
        .freeTags(freeTags),
        .freeCount(freeCount),
        .commitUop(commitUop),
        .commitPrevTags(commitPrevTags),
        .branch(branch)
    );

    renameStage #(
        .issueWidth(issueWidth),
        .wbWidth(wbWidth)
    ) renameStage_inst (
        .clk(clk),
        .rst(rst),
        .frontEn(frontEn),
        .outStall(outStall),
        .decUop(decUop),
        .renUop(renUop),
        .stall(stall),
        .nextSqN(nextSqN),
        .lookupIds(lookupIds),
        .lookupTags(lookupTags),
        .lookupAvail(lookupAvail),
        .issueValid(issueValid),
        .issueIds(issueIds),
        .issueTags(issueTags),
        .allocValid(allocValid),
        .freeTags(freeTags),
        .freeCount(freeCount),
        .wbUop(wbUop),
        .branch(branch)
    );

endmodule

// File: tbRename.sv
`timescale 1ns/1ps

module tbRename;

    localparam int issueWidth = 2;
    localparam int commitWidth = 2;
    localparam int wbWidth = 2;

    logic clk;
    logic rst;
    logic frontEn;
    logic outStall;
    renamePkg::DecUop decUop [issueWidth];
    renamePkg::CommitUop commitUop [commitWidth];
    renamePkg::WbUop wbUop [wbWidth];
    renamePkg::BranchInfo branch;
    renamePkg::RenUop renUop [issueWidth];
    logic stall;
    renamePkg::SqN nextSqN;

    // Reference model state
    renamePkg::Tag specMapM [renamePkg::numArchRegs];
    renamePkg::Tag comMapM [renamePkg::numArchRegs];
    renamePkg::Tag freeList [$];
    int specUsed;
    logic readyM [renamePkg::numTags];
    renamePkg::SqN sqNM;
    renamePkg::SqN lastComSqN;
    renamePkg::RenUop pendingOps [$];
    renamePkg::RenUop expOut [issueWidth];

    logic [7:0] lfsrState;
    logic lastStall;
    int errors;
    int timeouts;

    renameTop #(
        .issueWidth(issueWidth),
        .commitWidth(commitWidth),
        .wbWidth(wbWidth)
    ) renameTop_inst (
        .clk(clk),
        .rst(rst),
        .decUop(decUop),
        .frontEn(frontEn),
        .outStall(outStall),
        .commitUop(commitUop),
        .wbUop(wbUop),
        .branch(branch),
        .renUop(renUop),
        .stall(stall),
        .nextSqN(nextSqN)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR with taps x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsrNext(logic [7:0] s);
        logic [7:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 8'hB8;
        end
        return n;
    endfunction

    function automatic logic [31:0] randomBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic renamePkg::RegId randReg();
        return renamePkg::RegId'(randomBits(5));
    endfunction

    function automatic renamePkg::DecUop makeOp(renamePkg::RegId rs1, renamePkg::RegId rs2,
                                                renamePkg::RegId rd);
        renamePkg::DecUop d;
        d.valid = 1'b1;
        d.rs1 = rs1;
        d.rs2 = rs2;
        d.rd = rd;
        d.fu = renamePkg::FuType'(3'(rd % 5));
        d.imm = {27'h0, rd} + 32'h40;
        return d;
    endfunction

    function automatic renamePkg::DecUop randomOp();
        renamePkg::DecUop d;
        d = makeOp(randReg(), randReg(), randReg());
        // Roughly one slot in eight stays empty
        d.valid = (randomBits(3) != 0);
        return d;
    endfunction

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    task automatic checkTag(string name, renamePkg::Tag got, renamePkg::Tag exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    task automatic checkSqN(string name, renamePkg::SqN got, renamePkg::SqN exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    task automatic checkRenUop(string name, renamePkg::RenUop got, renamePkg::RenUop exp);
        checkBit({name, ".valid"}, got.valid, exp.valid);
        if (exp.valid && got.valid) begin
            checkTag({name, ".tagA"}, got.tagA, exp.tagA);
            checkBit({name, ".availA"}, got.availA, exp.availA);
            checkTag({name, ".tagB"}, got.tagB, exp.tagB);
            checkBit({name, ".availB"}, got.availB, exp.availB);
            checkBit({name, ".hasDst"}, got.hasDst, exp.hasDst);
            if (exp.hasDst) begin
                checkTag({name, ".tagDst"}, got.tagDst, exp.tagDst);
            end
            checkSqN({name, ".sqN"}, got.sqN, exp.sqN);
            if (got.rd !== exp.rd || got.fu !== exp.fu || got.imm !== exp.imm) begin
                errors++;
                $display("MISMATCH t=%0t %s.rd/fu/imm got=%0d/%0d/%h exp=%0d/%0d/%h", $time,
                         name, got.rd, got.fu, got.imm, exp.rd, exp.fu, exp.imm);
            end
        end
    endtask

    task automatic setIdle();
        frontEn = 1'b0;
        outStall = 1'b0;
        branch = '0;
        for (int i = 0; i < issueWidth; i++) begin
            decUop[i] = '0;
        end
        for (int i = 0; i < commitWidth; i++) begin
            commitUop[i] = '0;
        end
        for (int i = 0; i < wbWidth; i++) begin
            wbUop[i] = '0;
        end
    endtask

    task automatic resetModel();
        for (int r = 0; r < renamePkg::numArchRegs; r++) begin
            specMapM[r] = renamePkg::Tag'(r);
            comMapM[r] = renamePkg::Tag'(r);
        end
        for (int t = 0; t < renamePkg::numTags; t++) begin
            readyM[t] = 1'b1;
        end
        freeList.delete();
        for (int t = renamePkg::numArchRegs; t < renamePkg::numTags; t++) begin
            freeList.push_back(renamePkg::Tag'(t));
        end
        specUsed = 0;
        sqNM = '0;
        lastComSqN = '0;
        pendingOps.delete();
        for (int i = 0; i < issueWidth; i++) begin
            expOut[i] = '0;
        end
    endtask

    // Slots are renamed in order, so an older slot's new mapping is seen by a younger one
    function automatic renamePkg::RenUop renameOne(renamePkg::DecUop d);
        renamePkg::RenUop r;
        r = '0;
        if (d.valid) begin
            r.valid = 1'b1;
            r.tagA = specMapM[d.rs1];
            r.availA = readyM[r.tagA];
            r.tagB = specMapM[d.rs2];
            r.availB = readyM[r.tagB];
            r.hasDst = (d.rd != 0);
            if (r.hasDst) begin
                r.tagDst = freeList[specUsed];
                specUsed++;
                specMapM[d.rd] = r.tagDst;
                readyM[r.tagDst] = 1'b0;
            end
            r.rd = d.rd;
            r.sqN = sqNM;
            sqNM = sqNM + 7'd1;
            r.fu = d.fu;
            r.imm = d.imm;
            pendingOps.push_back(r);
        end
        return r;
    endfunction

    // Runs one clock on the caller's inputs and checks the result against the model
    task automatic runCycle();
        int need;
        logic expStall;
        logic accept;
        renamePkg::Tag prevTag;
        need = 0;
        #20;
        for (int i = 0; i < issueWidth; i++) begin
            if (decUop[i].valid && decUop[i].rd != 0) begin
                need++;
            end
        end
        expStall = outStall || (need > freeList.size() - specUsed);
        checkBit("stall", stall, expStall);
        lastStall = stall;
        accept = frontEn && !expStall && !branch.taken;

        // Writeback goes first because lookups of this cycle already see it
        for (int w = 0; w < wbWidth; w++) begin
            if (wbUop[w].valid) begin
                readyM[wbUop[w].tag] = 1'b1;
                for (int i = 0; i < issueWidth; i++) begin
                    if (outStall && !branch.taken && expOut[i].valid) begin
                        if (expOut[i].tagA == wbUop[w].tag) begin
                            expOut[i].availA = 1'b1;
                        end
                        if (expOut[i].tagB == wbUop[w].tag) begin
                            expOut[i].availB = 1'b1;
                        end
                    end
                end
            end
        end

        if (accept) begin
            for (int i = 0; i < issueWidth; i++) begin
                expOut[i] = renameOne(decUop[i]);
            end
        end else if (branch.taken || !outStall) begin
            for (int i = 0; i < issueWidth; i++) begin
                expOut[i].valid = 1'b0;
            end
        end

        for (int c = 0; c < commitWidth; c++) begin
            if (commitUop[c].valid && commitUop[c].rd != 0) begin
                prevTag = comMapM[commitUop[c].rd];
                comMapM[commitUop[c].rd] = commitUop[c].tagDst;
                void'(freeList.pop_front());
                freeList.push_back(prevTag);
                specUsed--;
            end
        end

        if (branch.taken) begin
            specMapM = comMapM;
            specUsed = 0;
            sqNM = branch.sqN + 7'd1;
            pendingOps.delete();
        end

        @(posedge clk);
        #1;
        for (int i = 0; i < issueWidth; i++) begin
            checkRenUop($sformatf("renUop[%0d]", i), renUop[i], expOut[i]);
        end
        checkSqN("nextSqN", nextSqN, sqNM);
        setIdle();
    endtask

    task automatic renameGroup(renamePkg::DecUop op0, renamePkg::DecUop op1);
        decUop[0] = op0;
        decUop[1] = op1;
        frontEn = 1'b1;
        runCycle();
    endtask

    task automatic commitOldest(int n);
        renamePkg::RenUop r;
        for (int i = 0; i < commitWidth; i++) begin
            if (i < n && pendingOps.size() > 0) begin
                r = pendingOps.pop_front();
                commitUop[i] = '{1'b1, r.rd, r.tagDst};
                lastComSqN = r.sqN;
            end
        end
        runCycle();
    endtask

    task automatic commitAll();
        int tries;
        tries = 0;
        while (pendingOps.size() > 0 && tries < 64) begin
            commitOldest(2);
            tries++;
        end
        if (pendingOps.size() > 0) begin
            timeouts++;
            $display("TIMEOUT: %0d ops still not committed", pendingOps.size());
        end
    endtask

    task automatic resetMappings();
        renameGroup(makeOp(1, 2, 3), makeOp(4, 5, 6));
        checkTag("renUop[0].tagA", renUop[0].tagA, 6'd1);
        checkBit("renUop[0].availA", renUop[0].availA, 1'b1);
        checkTag("renUop[0].tagDst", renUop[0].tagDst, 6'd32);
        checkTag("renUop[1].tagDst", renUop[1].tagDst, 6'd33);
        checkSqN("renUop[1].sqN", renUop[1].sqN, 7'd1);
        renameGroup(makeOp(3, 6, 7), makeOp(8, 9, 10));
        checkTag("renUop[0].tagDst", renUop[0].tagDst, 6'd34);
        checkSqN("renUop[0].sqN", renUop[0].sqN, 7'd2);
    endtask

    task automatic randomChain();
        repeat (6) renameGroup(randomOp(), randomOp());
        // Bypass from slot 0 into slot 1 which writes x0
        renameGroup(makeOp(randReg(), randReg(), 12), makeOp(12, 12, 0));
        checkBit("renUop[1].hasDst", renUop[1].hasDst, 1'b0);
        // Same rd in both slots so the reader must see slot 1's tag
        renameGroup(makeOp(1, 2, 13), makeOp(3, 4, 13));
        renameGroup(makeOp(13, 0, 0), makeOp(0, 13, 14));
    endtask

    task automatic freeTagExhaust();
        int tries;
        renamePkg::RegId r;
        // Empty window first so each group below commits as one pair
        commitAll();
        tries = 0;
        lastStall = 1'b0;
        while (!lastStall && tries < 40) begin
            r = renamePkg::RegId'(5'd16 + randomBits(2));
            renameGroup(makeOp(r, 1, r), makeOp(r, 2, r));
            tries++;
        end
        if (!lastStall) begin
            timeouts++;
            $display("TIMEOUT: stall never rose after %0d groups", tries);
        end
        // The oldest pair writes one rd twice and its freed tags are the only free ones
        commitOldest(2);
        renameGroup(makeOp(15, 1, 15), makeOp(15, 2, 15));
        commitAll();
        repeat (3) renameGroup(randomOp(), randomOp());
    endtask

    task automatic writebackReady();
        renameGroup(makeOp(1, 2, 20), makeOp(3, 4, 21));
        wbUop[0] = '{1'b1, specMapM[20]};
        renameGroup(makeOp(20, 21, 0), makeOp(21, 20, 0));
        wbUop[0] = '{1'b1, specMapM[21]};
        runCycle();
        renameGroup(makeOp(21, 20, 0), randomOp());

        renameGroup(makeOp(1, 2, 22), makeOp(3, 4, 23));
        renameGroup(makeOp(22, 23, 0), makeOp(23, 22, 24));
        outStall = 1'b1;
        frontEn = 1'b1;
        decUop[0] = makeOp(1, 2, 0);
        wbUop[0] = '{1'b1, specMapM[22]};
        runCycle();
        outStall = 1'b1;
        wbUop[1] = '{1'b1, specMapM[23]};
        runCycle();
        checkBit("renUop[0].valid held", renUop[0].valid, 1'b1);
        checkBit("renUop[0].availB held", renUop[0].availB, 1'b1);
        runCycle();
    endtask

    task automatic mispredictFlush();
        commitAll();
        renameGroup(makeOp(1, 2, 25), makeOp(3, 4, 26));
        commitOldest(2);
        renameGroup(makeOp(25, 26, 25), makeOp(26, 25, 27));
        renameGroup(makeOp(27, 0, 26), randomOp());
        // The flush must also drop an output that outStall would hold
        outStall = 1'b1;
        frontEn = 1'b1;
        decUop[0] = makeOp(5, 6, 7);
        branch = '{1'b1, lastComSqN};
        runCycle();
        checkSqN("nextSqN after flush", nextSqN, lastComSqN + 7'd1);
        renameGroup(makeOp(25, 27, 28), makeOp(26, 0, 25));
        renameGroup(randomOp(), randomOp());
    endtask

    initial begin
        errors = 0;
        timeouts = 0;
        lastStall = 1'b0;
        lfsrState = 8'd89;
        rst = 1'b1;
        setIdle();
        resetModel();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        runCycle();

        resetMappings();
        randomChain();
        freeTagExhaust();
        writebackReady();
        mispredictFlush();

        $display("Summary: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src.f
renamePkg.sv
renameTable.sv
tagBuffer.sv
renameStage.sv
renameTop.sv
tbRename.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module tbRename -f src.f

sim:
	verilator --binary --timing -Wno-fatal --top-module tbRename -f src.f --Mdir obj_dir
	./obj_dir/VtbRename > sim.log 2>&1; cat sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
